// File: dv/id_stage_trace.txt
# test instr valid pc br_taken ex_ready wdata_ex wdata_lsu, then expected:
# alu_op op_a op_b data_req data_we data_wdata id_ready br_set jmp_set illegal mask(hex)
1 00500093 1 00000000 0 0 00000005 00000000 0 00000000 00000005 0 0 00000000 1 0 0 0 3ff
1 00108133 1 00000004 0 0 0000000a 00000000 0 00000005 00000005 0 0 00000005 1 0 0 0 3ff
2 fff00193 1 00000008 0 0 ffffffff 00000000 0 00000000 ffffffff 0 0 00000000 1 0 0 0 3ff
2 12345237 1 0000000c 0 0 12345000 00000000 0 00000000 12345000 0 0 ffffffff 1 0 0 0 3ff
2 00001297 1 00000100 0 0 00001100 00000000 0 00000100 00001000 0 0 00000000 1 0 0 0 3ff
3 0000a303 1 00000104 0 0 11111111 deadbeef 0 00000005 00000000 1 0 00000000 0 0 0 0 3ff
3 0000a303 1 00000104 0 0 11111111 deadbeef 0 00000005 00000000 1 0 00000000 0 0 0 0 3ff
3 0000a303 1 00000104 0 1 11111111 deadbeef 0 00000005 00000000 1 0 00000000 1 0 0 0 3ff
3 000303b3 1 00000108 0 0 00000000 00000000 0 deadbeef 00000000 0 0 00000000 1 0 0 0 3ff
4 0040a423 1 0000010c 0 0 55555555 00000000 0 00000005 00000008 1 1 12345000 0 0 0 0 3ff
4 0040a423 1 0000010c 0 1 55555555 00000000 0 00000005 00000008 1 1 12345000 1 0 0 0 3ff
4 000404b3 1 00000110 0 0 00000000 00000000 0 00000000 00000000 0 0 00000000 1 0 0 0 3ff
4 00700013 1 00000114 0 0 77777777 00000000 0 00000000 00000007 0 0 00000000 1 0 0 0 3ff
4 00000533 1 00000118 0 0 00000000 00000000 0 00000000 00000000 0 0 00000000 1 0 0 0 3ff
5 00108863 1 00000200 1 0 00000000 00000000 1 00000005 00000005 0 0 00000005 0 0 0 0 3ff
5 00108863 1 00000200 1 0 00000000 00000000 1 00000005 00000005 0 0 00000005 0 1 0 0 3ff
5 00108863 1 00000200 1 1 00000000 00000000 1 00000005 00000005 0 0 00000005 1 0 0 0 3ff
5 00109863 1 00000204 0 0 00000000 00000000 1 00000005 00000005 0 0 00000005 1 0 0 0 3ff
5 020005ef 1 00000208 0 0 0000020c 00000000 0 00000208 00000004 0 0 00000000 0 0 1 0 3ff
5 020005ef 1 00000208 0 1 0000020c 00000000 0 00000208 00000004 0 0 00000000 1 0 0 0 3ff
5 00058633 1 0000020c 0 0 00000000 00000000 0 0000020c 00000000 0 0 00000000 1 0 0 0 3ff
6 000000ff 1 00000300 0 0 99999999 00000000 0 00000000 00000000 0 0 00000000 1 0 0 1 3f8
6 000086b3 1 00000304 0 0 00000000 00000000 0 00000005 00000000 0 0 00000000 1 0 0 0 3ff
6 0000a303 0 00000308 0 0 00000000 00000000 0 00000005 00000000 0 0 00000000 1 0 0 0 3ff

// File: compile.f
+incdir+logic
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operand_mux.sv
logic/id_register_file.sv
logic/id_wb_fsm.sv
logic/id_stage.sv
dv/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it.
# Exits non-zero unless the simulation log reports a pass.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module id_stage_tb \
  -Mdir "$build_dir" -o id_stage_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $build_log"
  exit 1
fi

"./$build_dir/id_stage_sim" > "$sim_log" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status, see $sim_log"
  exit 1
fi

if grep -qx "test passed" "$sim_log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see $sim_log"
exit 1

// File: dv/id_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// Trace-driven testbench for the decode stage top level.
// Each trace line is one cycle of inputs plus the expected outputs.
// Run from the project root so the trace path resolves.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;

  localparam int    half_period = 50;
  localparam string trace_path  = "dv/id_stage_trace.txt";

  // One trace line with inputs, expected outputs and the check mask
  typedef struct packed {
    logic [31:0] test;
    logic [31:0] instr;
    logic        valid;
    logic [31:0] pc;
    logic        br_taken;
    logic        ex_ready;
    logic [31:0] wdata_ex;
    logic [31:0] wdata_lsu;
    logic [3:0]  alu_op;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        req;
    logic        we;
    logic [31:0] wdata;
    logic        ready;
    logic        br_set;
    logic        jmp_set;
    logic        illegal;
    logic [9:0]  mask;
  } trace_line_t;

  logic              clk;
  logic              rst_n;
  logic [31:0]       instr;
  logic              instr_valid;
  logic [31:0]       pc_id;
  logic              branch_decision;
  logic              ex_ready;
  logic [31:0]       wdata_ex;
  logic [31:0]       wdata_lsu;
  id_pkg::alu_op_e   alu_operator;
  logic [31:0]       operand_a;
  logic [31:0]       operand_b;
  logic              data_req;
  logic              data_we;
  id_pkg::mem_type_e data_type;
  logic              data_sign_ext;
  logic [31:0]       data_wdata;
  logic              id_ready;
  logic              branch_set;
  logic              jump_set;
  logic              illegal_insn;

  trace_line_t trace_q[$];
  int          cycle_count = 0;
  int          cycle_limit = 20;
  int          err_count   = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          test_errs   = 0;
  int          cur_test    = 0;

  id_stage i_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .instr_i             (instr),
    .instr_valid_i       (instr_valid),
    .pc_id_i             (pc_id),
    .branch_decision_i   (branch_decision),
    .ex_ready_i          (ex_ready),
    .regfile_wdata_ex_i  (wdata_ex),
    .regfile_wdata_lsu_i (wdata_lsu),
    .alu_operator_o      (alu_operator),
    .alu_operand_a_o     (operand_a),
    .alu_operand_b_o     (operand_b),
    .data_req_o          (data_req),
    .data_we_o           (data_we),
    .data_type_o         (data_type),
    .data_sign_ext_o     (data_sign_ext),
    .data_wdata_o        (data_wdata),
    .id_ready_o          (id_ready),
    .branch_set_o        (branch_set),
    .jump_set_o          (jump_set),
    .illegal_insn_o      (illegal_insn)
  );

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Run limit set from the trace length once it is loaded
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout, the run went past %0d cycles without finishing", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic load_trace();
    int          fd;
    int          line_no;
    int          n;
    string       text;
    logic [31:0] f [19];
    trace_line_t e;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      $display("could not open the trace file %s", trace_path);
      err_count++;
    end else begin
      line_no = 0;
      while ($fgets(text, fd) > 0) begin
        line_no++;
        if (text.len() > 1 && text.getc(0) != "#") begin
          n = $sscanf(text, "%d %h %d %h %d %d %h %h %h %h %h %d %d %h %d %d %d %d %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
          if (n != 19) begin
            $display("trace line %0d is malformed, only %0d of 19 fields read", line_no, n);
            err_count++;
          end else begin
            e.test      = f[0];
            e.instr     = f[1];
            e.valid     = f[2][0];
            e.pc        = f[3];
            e.br_taken  = f[4][0];
            e.ex_ready  = f[5][0];
            e.wdata_ex  = f[6];
            e.wdata_lsu = f[7];
            e.alu_op    = f[8][3:0];
            e.op_a      = f[9];
            e.op_b      = f[10];
            e.req       = f[11][0];
            e.we        = f[12][0];
            e.wdata     = f[13];
            e.ready     = f[14][0];
            e.br_set    = f[15][0];
            e.jmp_set   = f[16][0];
            e.illegal   = f[17][0];
            e.mask      = f[18][9:0];
            trace_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_field(input string name, input logic en,
                               input logic [31:0] got, input logic [31:0] want);
    if (en) begin
      check_count++;
      if (got !== want) begin
        $display("ERR %0d ns: case %0d %s is %h, expected %h",
                 $time, cur_test, name, got, want);
        err_count++;
        test_errs++;
      end
    end
  endtask

  // Access size as RV32I encodes it in funct3 of loads and stores
  function automatic id_pkg::mem_type_e access_size(input logic [2:0] funct3);
    case (funct3)
      3'b000, 3'b100: access_size = id_pkg::MEM_BYTE;
      3'b001, 3'b101: access_size = id_pkg::MEM_HALF;
      default:        access_size = id_pkg::MEM_WORD;
    endcase
  endfunction

  // LB, LH and LW sign-extend, LBU and LHU do not
  function automatic logic load_sign_ext(input logic [2:0] funct3);
    load_sign_ext = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
  endfunction

  // Mask bit order follows the expected columns of the trace
  task automatic check_outputs(input trace_line_t e);
    compare_field("alu_operator_o", e.mask[0], 32'(alu_operator), 32'(e.alu_op));
    compare_field("alu_operand_a_o", e.mask[1], operand_a, e.op_a);
    compare_field("alu_operand_b_o", e.mask[2], operand_b, e.op_b);
    compare_field("data_req_o", e.mask[3], 32'(data_req), 32'(e.req));
    compare_field("data_we_o", e.mask[4], 32'(data_we), 32'(e.we));
    compare_field("data_wdata_o", e.mask[5], data_wdata, e.wdata);
    compare_field("id_ready_o", e.mask[6], 32'(id_ready), 32'(e.ready));
    compare_field("branch_set_o", e.mask[7], 32'(branch_set), 32'(e.br_set));
    compare_field("jump_set_o", e.mask[8], 32'(jump_set), 32'(e.jmp_set));
    compare_field("illegal_insn_o", e.mask[9], 32'(illegal_insn), 32'(e.illegal));
    // Size and extension only mean something on a memory access
    if (e.mask[3] && e.req) begin
      compare_field("data_type_o", 1'b1, 32'(data_type),
                    32'(access_size(e.instr[14:12])));
      if (e.instr[6:0] == id_pkg::OPCODE_LOAD) begin
        compare_field("data_sign_ext_o", 1'b1, 32'(data_sign_ext),
                      32'(load_sign_ext(e.instr[14:12])));
      end
    end
  endtask

  task automatic close_test();
    $display("case %0d finished with %0d mismatches", cur_test, test_errs);
    test_count++;
  endtask

  initial begin : run_trace
    trace_line_t e;
    rst_n           = 1'b0;
    instr           = '0;
    instr_valid     = 1'b0;
    pc_id           = '0;
    branch_decision = 1'b0;
    ex_ready        = 1'b0;
    wdata_ex        = '0;
    wdata_lsu       = '0;

    load_trace();
    if (trace_q.size() == 0) begin
      $display("no test lines were read from the trace");
      err_count++;
    end
    cycle_limit = trace_q.size() + 20;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    foreach (trace_q[i]) begin
      e = trace_q[i];
      if (int'(e.test) != cur_test) begin
        if (cur_test != 0) begin
          close_test();
        end
        cur_test  = int'(e.test);
        test_errs = 0;
      end
      @(posedge clk);
      instr           <= e.instr;
      instr_valid     <= e.valid;
      pc_id           <= e.pc;
      branch_decision <= e.br_taken;
      ex_ready        <= e.ex_ready;
      wdata_ex        <= e.wdata_ex;
      wdata_lsu       <= e.wdata_lsu;
      // Outputs settle well before the falling edge
      @(negedge clk);
      check_outputs(e);
    end
    if (cur_test != 0) begin
      close_test();
    end

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/id_stage.sv
//////////////////////////////////////////////////////////////////////
// Decode stage top level.
// Connects decoder, operand mux, register file and write-back FSM.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_stage (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  id_pkg::word_t     instr_i,
  input  logic              instr_valid_i,
  input  id_pkg::word_t     pc_id_i,
  input  logic              branch_decision_i,
  input  logic              ex_ready_i,
  input  id_pkg::word_t     regfile_wdata_ex_i,
  input  id_pkg::word_t     regfile_wdata_lsu_i,
  output id_pkg::alu_op_e   alu_operator_o,
  output id_pkg::word_t     alu_operand_a_o,
  output id_pkg::word_t     alu_operand_b_o,
  output logic              data_req_o,
  output logic              data_we_o,
  output id_pkg::mem_type_e data_type_o,
  output logic              data_sign_ext_o,
  output id_pkg::word_t     data_wdata_o,
  output logic              id_ready_o,
  output logic              branch_set_o,
  output logic              jump_set_o,
  output logic              illegal_insn_o
);

  id_pkg::reg_addr_t  raddr_a, raddr_b, waddr;
  id_pkg::word_t      rdata_a, rdata_b, regfile_wdata;
  id_pkg::op_a_sel_e  op_a_sel;
  id_pkg::op_b_sel_e  op_b_sel;
  id_pkg::imm_b_sel_e imm_b_sel;
  logic               regfile_we_id, regfile_we, select_lsu;
  logic               branch_in_id, jump_in_id;

  assign raddr_a = instr_i[`ID_RS1_MSB:`ID_RS1_LSB];
  assign raddr_b = instr_i[`ID_RS2_MSB:`ID_RS2_LSB];
  assign waddr   = instr_i[`ID_RD_MSB:`ID_RD_LSB];

  assign regfile_wdata = select_lsu ? regfile_wdata_lsu_i : regfile_wdata_ex_i;
  // Store data is rs2 straight from the register file
  assign data_wdata_o  = rdata_b;

  id_decoder i_decoder (
    .instr_i         (instr_i),
    .instr_valid_i   (instr_valid_i),
    .alu_operator_o  (alu_operator_o),
    .op_a_sel_o      (op_a_sel),
    .op_b_sel_o      (op_b_sel),
    .imm_b_sel_o     (imm_b_sel),
    .regfile_we_o    (regfile_we_id),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_type_o     (data_type_o),
    .data_sign_ext_o (data_sign_ext_o),
    .branch_in_id_o  (branch_in_id),
    .jump_in_id_o    (jump_in_id),
    .illegal_insn_o  (illegal_insn_o)
  );

  id_operand_mux i_operand_mux (
    .instr_i     (instr_i),
    .pc_id_i     (pc_id_i),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .op_a_sel_i  (op_a_sel),
    .op_b_sel_i  (op_b_sel),
    .imm_b_sel_i (imm_b_sel),
    .operand_a_o (alu_operand_a_o),
    .operand_b_o (alu_operand_b_o)
  );

  id_register_file i_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (waddr),
    .wdata_i   (regfile_wdata),
    .we_i      (regfile_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_wb_fsm i_wb_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .data_req_i        (data_req_o),
    .regfile_we_id_i   (regfile_we_id),
    .branch_in_id_i    (branch_in_id),
    .jump_in_id_i      (jump_in_id),
    .branch_decision_i (branch_decision_i),
    .ex_ready_i        (ex_ready_i),
    .regfile_we_o      (regfile_we),
    .select_lsu_o      (select_lsu),
    .id_ready_o        (id_ready_o),
    .branch_set_o      (branch_set_o),
    .jump_set_o        (jump_set_o)
  );

endmodule

`default_nettype wire

// File: logic/id_wb_fsm.sv
//////////////////////////////////////////////////////////////////////
// Write-back FSM of the decode stage.
// Stalls ID on loads, stores, jumps and taken branches until execute
// reports ready, then releases the register write.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_wb_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic data_req_i,
  input  logic regfile_we_id_i,
  input  logic branch_in_id_i,
  input  logic jump_in_id_i,
  input  logic branch_decision_i,
  input  logic ex_ready_i,
  output logic regfile_we_o,
  output logic select_lsu_o,
  output logic id_ready_o,
  output logic branch_set_o,
  output logic jump_set_o
);

  id_pkg::wb_state_e state_q, state_d;
  logic              branch_set_q, branch_set_d;
  logic              load_stall, branch_stall, jump_stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= id_pkg::IDLE;
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      branch_set_q <= branch_set_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    regfile_we_o = regfile_we_id_i;
    select_lsu_o = 1'b0;
    load_stall   = 1'b0;
    branch_stall = 1'b0;
    jump_stall   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_o   = 1'b0;

    unique case (state_q)
      id_pkg::IDLE: begin
        if (data_req_i) begin
          // Loads and stores wait for the LSU
          regfile_we_o = 1'b0;
          load_stall   = 1'b1;
          state_d      = id_pkg::WAIT_MULTICYCLE;
        end else if (branch_in_id_i && branch_decision_i) begin
          branch_stall = 1'b1;
          branch_set_d = 1'b1;
          state_d      = id_pkg::WAIT_MULTICYCLE;
        end else if (jump_in_id_i) begin
          regfile_we_o = 1'b0;
          jump_stall   = 1'b1;
          jump_set_o   = 1'b1;
          state_d      = id_pkg::WAIT_MULTICYCLE;
        end
      end
      default: begin
        if (ex_ready_i) begin
          select_lsu_o = data_req_i;
          state_d      = id_pkg::IDLE;
        end else begin
          regfile_we_o = 1'b0;
          load_stall   = data_req_i;
          branch_stall = branch_in_id_i;
          jump_stall   = jump_in_id_i;
        end
      end
    endcase
  end

  assign id_ready_o   = ~(load_stall | branch_stall | jump_stall);
  assign branch_set_o = branch_set_q;

  a_branch_decision_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_in_id_i |-> !$isunknown(branch_decision_i));

endmodule

`default_nettype wire

// File: logic/id_register_file.sv
//////////////////////////////////////////////////////////////////////
// Flip-flop register file, two combinational read ports, one write port.
// Register 0 is hard-wired to zero.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_register_file (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`ID_REG_ADDR_W-1:0] raddr_b_i,
  input  logic [`ID_REG_ADDR_W-1:0] waddr_i,
  input  logic [`ID_XLEN-1:0]       wdata_i,
  input  logic                      we_i,
  output logic [`ID_XLEN-1:0]       rdata_a_o,
  output logic [`ID_XLEN-1:0]       rdata_b_o
);

  logic [`ID_XLEN-1:0] regs_q    [1:`ID_NUM_REGS-1];
  logic [`ID_XLEN-1:0] regs_view [`ID_NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `ID_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read view with the zero register in front
  always_comb begin
    regs_view[0] = '0;
    for (int i = 1; i < `ID_NUM_REGS; i++) begin
      regs_view[i] = regs_q[i];
    end
  end

  assign rdata_a_o = regs_view[raddr_a_i];
  assign rdata_b_o = regs_view[raddr_b_i];

  a_waddr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

// File: logic/id_operand_mux.sv
//////////////////////////////////////////////////////////////////////
// Immediate extraction and the two ALU operand muxes.
// Selects come from the decoder, register data from the register file.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_operand_mux (
  input  id_pkg::word_t      instr_i,
  input  id_pkg::word_t      pc_id_i,
  input  id_pkg::word_t      rdata_a_i,
  input  id_pkg::word_t      rdata_b_i,
  input  id_pkg::op_a_sel_e  op_a_sel_i,
  input  id_pkg::op_b_sel_e  op_b_sel_i,
  input  id_pkg::imm_b_sel_e imm_b_sel_i,
  output id_pkg::word_t      operand_a_o,
  output id_pkg::word_t      operand_b_o
);

  id_pkg::word_t imm_i_type;
  id_pkg::word_t imm_s_type;
  id_pkg::word_t imm_b_type;
  id_pkg::word_t imm_u_type;
  id_pkg::word_t imm_j_type;
  id_pkg::word_t imm_b;

  // Sign bit is always instr[31]
  assign imm_i_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{(`ID_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{(`ID_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Operand A
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (op_a_sel_i)
      id_pkg::OP_A_REG_A:  operand_a_o = rdata_a_i;
      id_pkg::OP_A_CURRPC: operand_a_o = pc_id_i;
      default:             operand_a_o = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand B
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (imm_b_sel_i)
      id_pkg::IMM_B_S:      imm_b = imm_s_type;
      id_pkg::IMM_B_B:      imm_b = imm_b_type;
      id_pkg::IMM_B_U:      imm_b = imm_u_type;
      id_pkg::IMM_B_J:      imm_b = imm_j_type;
      id_pkg::IMM_B_PCINCR: imm_b = id_pkg::word_t'(4);
      default:              imm_b = imm_i_type;
    endcase
  end

  assign operand_b_o = (op_b_sel_i == id_pkg::OP_B_IMM) ? imm_b : rdata_b_i;

endmodule

`default_nettype wire

// File: logic/id_decoder.sv
//////////////////////////////////////////////////////////////////////
// Instruction decoder for the reduced RV32I set.
// Purely combinational, driven from the instruction held in ID.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_decoder (
  input  id_pkg::word_t      instr_i,
  input  logic               instr_valid_i,
  output id_pkg::alu_op_e    alu_operator_o,
  output id_pkg::op_a_sel_e  op_a_sel_o,
  output id_pkg::op_b_sel_e  op_b_sel_o,
  output id_pkg::imm_b_sel_e imm_b_sel_o,
  output logic               regfile_we_o,
  output logic               data_req_o,
  output logic               data_we_o,
  output id_pkg::mem_type_e  data_type_o,
  output logic               data_sign_ext_o,
  output logic               branch_in_id_o,
  output logic               jump_in_id_o,
  output logic               illegal_insn_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    alu_operator_o  = id_pkg::ALU_ADD;
    op_a_sel_o      = id_pkg::OP_A_REG_A;
    op_b_sel_o      = id_pkg::OP_B_IMM;
    imm_b_sel_o     = id_pkg::IMM_B_I;
    regfile_we_o    = 1'b0;
    data_req_o      = 1'b0;
    data_we_o       = 1'b0;
    data_type_o     = id_pkg::MEM_WORD;
    data_sign_ext_o = 1'b0;
    branch_in_id_o  = 1'b0;
    jump_in_id_o    = 1'b0;
    illegal_insn_o  = 1'b0;

    unique case (id_pkg::opcode_e'(instr_i[6:0]))
      id_pkg::OPCODE_OP: begin
        op_b_sel_o   = id_pkg::OP_B_REG_B;
        regfile_we_o = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: alu_operator_o = id_pkg::ALU_ADD;
          {7'h20, 3'b000}: alu_operator_o = id_pkg::ALU_SUB;
          {7'h00, 3'b001}: alu_operator_o = id_pkg::ALU_SLL;
          {7'h00, 3'b010}: alu_operator_o = id_pkg::ALU_SLT;
          {7'h00, 3'b011}: alu_operator_o = id_pkg::ALU_SLTU;
          {7'h00, 3'b100}: alu_operator_o = id_pkg::ALU_XOR;
          {7'h00, 3'b101}: alu_operator_o = id_pkg::ALU_SRL;
          {7'h20, 3'b101}: alu_operator_o = id_pkg::ALU_SRA;
          {7'h00, 3'b110}: alu_operator_o = id_pkg::ALU_OR;
          {7'h00, 3'b111}: alu_operator_o = id_pkg::ALU_AND;
          default:         illegal_insn_o = 1'b1;
        endcase
      end
      id_pkg::OPCODE_OP_IMM: begin
        regfile_we_o = 1'b1;
        unique case (funct3)
          3'b000: alu_operator_o = id_pkg::ALU_ADD;
          3'b010: alu_operator_o = id_pkg::ALU_SLT;
          3'b011: alu_operator_o = id_pkg::ALU_SLTU;
          3'b100: alu_operator_o = id_pkg::ALU_XOR;
          3'b110: alu_operator_o = id_pkg::ALU_OR;
          3'b111: alu_operator_o = id_pkg::ALU_AND;
          3'b001: begin
            alu_operator_o = id_pkg::ALU_SLL;
            illegal_insn_o = (funct7 != 7'h00);
          end
          default: begin
            // Shift right with funct7 picking logical or arithmetic
            alu_operator_o = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            illegal_insn_o = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      id_pkg::OPCODE_LUI: begin
        op_a_sel_o   = id_pkg::OP_A_ZERO;
        imm_b_sel_o  = id_pkg::IMM_B_U;
        regfile_we_o = 1'b1;
      end
      id_pkg::OPCODE_AUIPC: begin
        op_a_sel_o   = id_pkg::OP_A_CURRPC;
        imm_b_sel_o  = id_pkg::IMM_B_U;
        regfile_we_o = 1'b1;
      end
      id_pkg::OPCODE_LOAD: begin
        data_req_o      = 1'b1;
        regfile_we_o    = 1'b1;
        data_type_o     = id_pkg::mem_type_e'(funct3[1:0]);
        data_sign_ext_o = ~funct3[2];
        illegal_insn_o  = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      id_pkg::OPCODE_STORE: begin
        data_req_o     = 1'b1;
        data_we_o      = 1'b1;
        imm_b_sel_o    = id_pkg::IMM_B_S;
        data_type_o    = id_pkg::mem_type_e'(funct3[1:0]);
        illegal_insn_o = funct3[2] || (funct3[1:0] == 2'b11);
      end
      id_pkg::OPCODE_BRANCH: begin
        branch_in_id_o = 1'b1;
        op_b_sel_o     = id_pkg::OP_B_REG_B;
        unique case (funct3[2:1])
          2'b00:   alu_operator_o = id_pkg::ALU_SUB;
          2'b10:   alu_operator_o = id_pkg::ALU_SLT;
          2'b11:   alu_operator_o = id_pkg::ALU_SLTU;
          default: illegal_insn_o = 1'b1;
        endcase
      end
      id_pkg::OPCODE_JAL: begin
        // Link value PC + 4
        // Jump target is formed in fetch
        jump_in_id_o = 1'b1;
        regfile_we_o = 1'b1;
        op_a_sel_o   = id_pkg::OP_A_CURRPC;
        imm_b_sel_o  = id_pkg::IMM_B_PCINCR;
      end
      default: illegal_insn_o = 1'b1;
    endcase

    if (illegal_insn_o) begin
      regfile_we_o   = 1'b0;
      data_req_o     = 1'b0;
      data_we_o      = 1'b0;
      branch_in_id_o = 1'b0;
      jump_in_id_o   = 1'b0;
    end

    // No side effects without a valid instruction
    if (!instr_valid_i) begin
      regfile_we_o   = 1'b0;
      data_req_o     = 1'b0;
      branch_in_id_o = 1'b0;
      jump_in_id_o   = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/id_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types shared by the decode stage modules.
// Refer to them as id_pkg::name.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "id_macros.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]       word_t;
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes of the reduced base set
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_STORE  = 7'b0100011,
    OPCODE_OP     = 7'b0110011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_BRANCH = 7'b1100011,
    OPCODE_JAL    = 7'b1101111
  } opcode_e;

  // Branch compares reuse SUB, SLT and SLTU
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_PCINCR
  } imm_b_sel_e;

  // Encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {MEM_BYTE = 2'b00, MEM_HALF = 2'b01, MEM_WORD = 2'b10} mem_type_e;

  typedef enum logic {IDLE, WAIT_MULTICYCLE} wb_state_e;

endpackage

`default_nettype wire

// File: logic/id_macros.svh
//////////////////////////////////////////////////////////////////////
// Width and instruction field constants for the decode stage.
// Include this in any file that sizes a word or slices a register field.
//////////////////////////////////////////////////////////////////////

`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Data path
`define ID_XLEN        32
`define ID_NUM_REGS    32
`define ID_REG_ADDR_W  5

// Register fields inside the instruction word
`define ID_RS1_MSB     19
`define ID_RS1_LSB     15
`define ID_RS2_MSB     24
`define ID_RS2_LSB     20
`define ID_RD_MSB      11
`define ID_RD_LSB      7

`endif
